// File: filelist.f
+incdir+logic
logic/qenc_cfg_pkg.sv
logic/qenc_status_pkg.sv
logic/qenc_input_filter.sv
logic/qenc_step_decoder.sv
logic/qenc_position_counter.sv
logic/qenc_config_regs.sv
logic/qenc_capture_top.sv
tests/qenc_clock_gen.sv
tests/qenc_capture_tb.sv

// File: Makefile
VERILATOR  ?= verilator
VFLAGS     ?= --binary --timing -j 0
LINT_FLAGS ?= --lint-only --timing
TOP        ?= qenc_capture_tb
FILELIST   ?= filelist.f
OBJ_DIR    ?= obj_dir

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "^Simulation PASSED$$"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

// File: tests/qenc_capture_tb.sv
`timescale 1ns/1ns
`default_nettype none

`include "qenc_consts.svh"

module qenc_capture_tb;

    import qenc_cfg_pkg::*;

    localparam int PHASE_CYCLES     = 8;
    localparam int MAX_STEPS        = 19;
    localparam int GLITCHES         = 8;
    localparam int JUMPS            = 5;
    localparam int STEP_REF_ILLEGAL = 2;
    localparam int PLANNED_PHASES   = 5 * MAX_STEPS + 3 + 2 * GLITCHES + 2 * JUMPS;
    localparam int WATCHDOG_CYCLES  = PLANNED_PHASES * PHASE_CYCLES + 600;

    logic                         clk;
    logic                         reset;
    logic [`QENC_CHANNELS-1:0]    enc_a;
    logic [`QENC_CHANNELS-1:0]    enc_b;
    logic                         latch_in;
    logic                         wr_en;
    logic [`QENC_ADDR_WIDTH-1:0]  addr;
    logic [`QENC_DATA_WIDTH-1:0]  wr_data;
    logic [`QENC_DATA_WIDTH-1:0]  rd_data;

    // encoder model state per channel
    int                           pin_idx [`QENC_CHANNELS];
    logic                         pin_a [`QENC_CHANNELS];
    logic                         pin_b [`QENC_CHANNELS];
    logic                         swap_exp [`QENC_CHANNELS];
    logic [`QENC_COUNT_WIDTH-1:0] run_count_exp [`QENC_CHANNELS];
    logic [`QENC_COUNT_WIDTH-1:0] lat_count_exp [`QENC_CHANNELS];
    logic [`QENC_ERR_WIDTH-1:0]   run_err_exp [`QENC_CHANNELS];
    logic [`QENC_ERR_WIDTH-1:0]   lat_err_exp [`QENC_CHANNELS];

    logic                         rd_pending;
    logic [`QENC_DATA_WIDTH-1:0]  exp_q [$];
    string                        what_q [$];
    int                           check_count;
    int                           error_count;
    integer                       seed = 32'h8cba;

    qenc_clock_gen #(.PERIOD_NS(4), .RESET_CYCLES(10)) u_clock (
        .clk   (clk),
        .reset (reset)
    );

    qenc_capture_top DUT (
        .clk      (clk),
        .reset    (reset),
        .enc_a    (enc_a),
        .enc_b    (enc_b),
        .latch_in (latch_in),
        .wr_en    (wr_en),
        .addr     (addr),
        .wr_data  (wr_data),
        .rd_data  (rd_data)
    );

    // ************************************************************
    // reference model
    // ************************************************************

    // position in the Gray order 00, 01, 11, 10 of {b, a}
    function automatic int gray_index(input logic a, input logic b);
        case ({b, a})
            2'b00: return 0;
            2'b01: return 1;
            2'b11: return 2;
            default: return 3;
        endcase
    endfunction

    // +1, -1, 0 or STEP_REF_ILLEGAL for one phase change
    function automatic int step_ref(input logic prev_a, input logic prev_b,
                                    input logic new_a, input logic new_b,
                                    input logic swap);
        int diff;
        if (swap) begin
            diff = gray_index(new_b, new_a) - gray_index(prev_b, prev_a);
        end else begin
            diff = gray_index(new_a, new_b) - gray_index(prev_a, prev_b);
        end
        case ((diff + 4) % 4)
            0: return 0;
            1: return 1;
            3: return -1;
            default: return STEP_REF_ILLEGAL;
        endcase
    endfunction

    task automatic latch_model(input chan_mask_t mask);
        for (int ch = 0; ch < `QENC_CHANNELS; ch++) begin
            if (mask[ch]) begin
                lat_count_exp[ch] = run_count_exp[ch];
                lat_err_exp[ch]   = run_err_exp[ch];
                run_count_exp[ch] = '0;
                run_err_exp[ch]   = '0;
            end
        end
    endtask

    // ************************************************************
    // stimulus tasks
    // ************************************************************

    // delta 1 forward, -1 reverse, 2 moves both lines at once
    task automatic move_phase(input int ch, input int delta);
        int   new_idx;
        int   r;
        logic na;
        logic nb;
        new_idx = (pin_idx[ch] + delta + 4) % 4;
        na = (new_idx == 1) || (new_idx == 2);
        nb = (new_idx >= 2);
        r = step_ref(pin_a[ch], pin_b[ch], na, nb, swap_exp[ch]);
        if (r == STEP_REF_ILLEGAL) begin
            if (run_err_exp[ch] != '1) begin
                run_err_exp[ch] = run_err_exp[ch] + `QENC_ERR_WIDTH'(1);
            end
        end else begin
            run_count_exp[ch] = run_count_exp[ch] + r[`QENC_COUNT_WIDTH-1:0];
        end
        pin_idx[ch] = new_idx;
        pin_a[ch]   = na;
        pin_b[ch]   = nb;
        @(posedge clk);
        enc_a[ch] <= na;
        enc_b[ch] <= nb;
        repeat (PHASE_CYCLES - 1) @(posedge clk);
    endtask

    task automatic rotate(input int ch, input int n, input int dir);
        for (int i = 0; i < n; i++) begin
            move_phase(ch, dir);
        end
    endtask

    // single cycle pulse on one line and then on the other
    // if either pulse leaked the decoder would see both lines move
    task automatic glitch_lines(input int ch, input int first);
        @(posedge clk);
        enc_a[ch] <= pin_a[ch] ^ (first == 0);
        enc_b[ch] <= pin_b[ch] ^ (first != 0);
        @(posedge clk);
        enc_a[ch] <= pin_a[ch] ^ (first != 0);
        enc_b[ch] <= pin_b[ch] ^ (first == 0);
        @(posedge clk);
        enc_a[ch] <= pin_a[ch];
        enc_b[ch] <= pin_b[ch];
        repeat (PHASE_CYCLES - 2) @(posedge clk);
    endtask

    task automatic write_reg(input reg_addr_t a, input logic [`QENC_DATA_WIDTH-1:0] d);
        @(posedge clk);
        wr_en   <= 1'b1;
        addr    <= a;
        wr_data <= d;
        @(posedge clk);
        wr_en   <= 1'b0;
    endtask

    // pulse reaches the counters one cycle after the write, copy one later
    task automatic latch_by_write(input chan_mask_t mask);
        write_reg(ADDR_LATCH, `QENC_DATA_WIDTH'(mask));
        latch_model(mask);
        repeat (2) @(posedge clk);
    endtask

    task automatic pulse_latch_in();
        @(posedge clk);
        latch_in <= 1'b1;
        @(posedge clk);
        latch_in <= 1'b0;
        latch_model('1);
        repeat (2) @(posedge clk);
    endtask

    task automatic read_expect(input reg_addr_t a, input logic [`QENC_DATA_WIDTH-1:0] expected,
                               input string what);
        @(posedge clk);
        addr       <= a;
        rd_pending <= 1'b1;
        exp_q.push_back(expected);
        what_q.push_back(what);
        @(posedge clk);
        rd_pending <= 1'b0;
    endtask

    task automatic read_channel(input int ch, input string what);
        reg_addr_t count_addr;
        reg_addr_t err_addr;
        count_addr = (ch == 0) ? ADDR_COUNT0 : ADDR_COUNT1;
        err_addr   = (ch == 0) ? ADDR_ERR0 : ADDR_ERR1;
        read_expect(count_addr, lat_count_exp[ch], {what, " count"});
        read_expect(err_addr, {8'h00, lat_err_exp[ch]}, {what, " error count"});
    endtask

    // ************************************************************
    // checking
    // ************************************************************

    task automatic compare_value(input string what, input logic [`QENC_DATA_WIDTH-1:0] actual,
                                 input logic [`QENC_DATA_WIDTH-1:0] expected);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("Error at %0t: %s read 0x%h, expected 0x%h", $time, what, actual, expected);
        end
    endtask

    // rd_data is combinational from addr, stable by the falling edge
    always @(negedge clk) begin
        if (rd_pending) begin
            compare_value(what_q.pop_front(), rd_data, exp_q.pop_front());
        end
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("watchdog expired after %0d cycles, test sequence did not finish",
                 WATCHDOG_CYCLES);
        $display("Simulation FAILED");
        $finish;
    end

    // ************************************************************
    // test sequence
    // ************************************************************

    initial begin
        int n;
        int m;
        enc_a      <= '0;
        enc_b      <= '0;
        latch_in   <= 1'b0;
        wr_en      <= 1'b0;
        addr       <= '0;
        wr_data    <= '0;
        rd_pending <= 1'b0;
        check_count = 0;
        error_count = 0;
        for (int ch = 0; ch < `QENC_CHANNELS; ch++) begin
            pin_idx[ch]       = 0;
            pin_a[ch]         = 1'b0;
            pin_b[ch]         = 1'b0;
            swap_exp[ch]      = 1'b0;
            run_count_exp[ch] = '0;
            lat_count_exp[ch] = '0;
            run_err_exp[ch]   = '0;
            lat_err_exp[ch]   = '0;
        end
        @(negedge reset);
        repeat (2) @(posedge clk);

        // forward on channel 0
        n = ($random(seed) & 15) + 4;
        rotate(0, n, 1);
        latch_by_write(2'b01);
        read_channel(0, "forward ch0");

        // reverse on channel 1, channel 0 restarted at the last latch
        n = ($random(seed) & 15) + 4;
        rotate(1, n, -1);
        latch_by_write(2'b11);
        read_channel(1, "reverse ch1");
        read_channel(0, "idle ch0");

        // swap on channel 0, parked where A equals B
        while (pin_a[0] != pin_b[0]) begin
            move_phase(0, 1);
        end
        write_reg(ADDR_CTRL, 16'h0001);
        swap_exp[0] = 1'b1;
        read_expect(ADDR_CTRL, 16'h0001, "swap mask");
        read_expect(ADDR_LATCH, 16'h0000, "latch register");
        latch_by_write(2'b01);
        n = ($random(seed) & 15) + 4;
        rotate(0, n, 1);
        latch_by_write(2'b01);
        read_channel(0, "swapped ch0");

        // glitches between held phases
        latch_by_write(2'b11);
        for (int i = 0; i < GLITCHES; i++) begin
            glitch_lines($random(seed) & 1, ($random(seed) >> 1) & 1);
            if (i % 2 == 1) begin
                move_phase(i % 4 / 2, 1);
            end
        end
        latch_by_write(2'b11);
        read_channel(0, "glitch ch0");
        read_channel(1, "glitch ch1");

        // both lines in one step
        for (int i = 0; i < JUMPS; i++) begin
            move_phase(1, 2);
            move_phase(1, -1);
        end
        latch_by_write(2'b10);
        read_channel(1, "jump ch1");
        read_channel(0, "unlatched ch0");

        // external strobe latches both channels
        n = ($random(seed) & 15) + 4;
        m = ($random(seed) & 15) + 4;
        rotate(0, n, 1);
        rotate(1, m, -1);
        pulse_latch_in();
        read_channel(0, "strobe ch0");
        read_channel(1, "strobe ch1");
        pulse_latch_in();
        read_channel(0, "restart ch0");
        read_channel(1, "restart ch1");

        repeat (2) @(posedge clk);
        $display("checks %0d, errors %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: tests/qenc_clock_gen.sv
`timescale 1ns/1ns
`default_nettype none

module qenc_clock_gen #(
    parameter int PERIOD_NS    = 4,
    parameter int RESET_CYCLES = 10
) (
    output logic clk,
    output logic reset
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2) clk = ~clk;
    end

    initial begin
        reset <= 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        reset <= 1'b0;
    end

endmodule

`default_nettype wire

// File: logic/qenc_capture_top.sv
`timescale 1ns/1ns
`default_nettype none

`include "qenc_consts.svh"

module qenc_capture_top (
    input  logic                          clk,
    input  logic                          reset,
    input  logic [`QENC_CHANNELS-1:0]     enc_a,
    input  logic [`QENC_CHANNELS-1:0]     enc_b,
    input  logic                          latch_in,
    input  logic                          wr_en,
    input  logic [`QENC_ADDR_WIDTH-1:0]   addr,
    input  logic [`QENC_DATA_WIDTH-1:0]   wr_data,
    output logic [`QENC_DATA_WIDTH-1:0]   rd_data
);

    import qenc_cfg_pkg::*;
    import qenc_status_pkg::*;

    chan_mask_t swap;
    chan_mask_t latch;
    logic       filt_a [`QENC_CHANNELS];
    logic       filt_b [`QENC_CHANNELS];
    step_t      step [`QENC_CHANNELS];
    count_t     latched_count [`QENC_CHANNELS];
    err_count_t latched_err [`QENC_CHANNELS];

    qenc_config_regs u_regs (
        .clk           (clk),
        .reset         (reset),
        .wr_en         (wr_en),
        .addr          (addr),
        .wr_data       (wr_data),
        .latch_in      (latch_in),
        .latched_count (latched_count),
        .latched_err   (latched_err),
        .rd_data       (rd_data),
        .swap          (swap),
        .latch         (latch)
    );

    // ************************************************************
    // channel chains
    // ************************************************************

    for (genvar ch = 0; ch < `QENC_CHANNELS; ch++) begin : g_chan
        qenc_input_filter u_filter (
            .clk    (clk),
            .reset  (reset),
            .swap   (swap[ch]),
            .enc_a  (enc_a[ch]),
            .enc_b  (enc_b[ch]),
            .filt_a (filt_a[ch]),
            .filt_b (filt_b[ch])
        );

        qenc_step_decoder u_decoder (
            .clk    (clk),
            .reset  (reset),
            .filt_a (filt_a[ch]),
            .filt_b (filt_b[ch]),
            .step   (step[ch])
        );

        qenc_position_counter u_counter (
            .clk           (clk),
            .reset         (reset),
            .step          (step[ch]),
            .latch         (latch[ch]),
            .latched_count (latched_count[ch]),
            .latched_err   (latched_err[ch])
        );
    end

endmodule

`default_nettype wire

// File: logic/qenc_config_regs.sv
`timescale 1ns/1ns
`default_nettype none

`include "qenc_consts.svh"

module qenc_config_regs (
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          wr_en,
    input  logic [`QENC_ADDR_WIDTH-1:0]   addr,
    input  logic [`QENC_DATA_WIDTH-1:0]   wr_data,
    input  logic                          latch_in,
    input  qenc_status_pkg::count_t       latched_count [`QENC_CHANNELS],
    input  qenc_status_pkg::err_count_t   latched_err [`QENC_CHANNELS],
    output logic [`QENC_DATA_WIDTH-1:0]   rd_data,
    output qenc_cfg_pkg::chan_mask_t      swap,
    output qenc_cfg_pkg::chan_mask_t      latch
);

    import qenc_cfg_pkg::*;

    reg_addr_t  reg_addr;
    chan_mask_t wr_mask;
    chan_mask_t latch_next;

    assign reg_addr = reg_addr_t'(addr);
    assign wr_mask  = wr_data[`QENC_CHANNELS-1:0];

    // ************************************************************
    // write side
    // ************************************************************

    // register write picks channels by mask, strobe takes all
    always_comb begin
        latch_next = {`QENC_CHANNELS{latch_in}};
        if (wr_en && reg_addr == ADDR_LATCH) begin
            latch_next = latch_next | wr_mask;
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            swap <= '0;
        end else if (wr_en && reg_addr == ADDR_CTRL) begin
            swap <= wr_mask;
        end
    end

    // one cycle pulse per channel
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            latch <= '0;
        end else begin
            latch <= latch_next;
        end
    end

    // ************************************************************
    // readback
    // ************************************************************

    // latch register is write only
    always_comb begin
        case (reg_addr)
            ADDR_CTRL: begin
                rd_data = `QENC_DATA_WIDTH'(swap);
            end
            ADDR_COUNT0: begin
                rd_data = `QENC_DATA_WIDTH'(latched_count[0]);
            end
            ADDR_COUNT1: begin
                rd_data = `QENC_DATA_WIDTH'(latched_count[1]);
            end
            ADDR_ERR0: begin
                rd_data = `QENC_DATA_WIDTH'(latched_err[0]);
            end
            ADDR_ERR1: begin
                rd_data = `QENC_DATA_WIDTH'(latched_err[1]);
            end
            default: begin
                rd_data = '0;
            end
        endcase
    end

endmodule

`default_nettype wire

// File: logic/qenc_position_counter.sv
`timescale 1ns/1ns
`default_nettype none

module qenc_position_counter (
    input  logic                        clk,
    input  logic                        reset,
    input  qenc_status_pkg::step_t      step,
    input  logic                        latch,
    output qenc_status_pkg::count_t     latched_count,
    output qenc_status_pkg::err_count_t latched_err
);

    import qenc_status_pkg::*;

    count_t     run_count;
    err_count_t run_err;
    count_t     base_count;
    err_count_t base_err;
    count_t     next_count;
    err_count_t next_err;

    // a latch restarts from zero, a step in the same cycle still counts
    assign base_count = latch ? '0 : run_count;
    assign base_err   = latch ? '0 : run_err;

    always_comb begin
        case (step)
            STEP_UP:   next_count = base_count + count_t'(1);
            STEP_DOWN: next_count = base_count - count_t'(1);
            default:   next_count = base_count;
        endcase
    end

    // stick at the top
    always_comb begin
        if (step == STEP_ILLEGAL && base_err != '1) begin
            next_err = base_err + err_count_t'(1);
        end else begin
            next_err = base_err;
        end
    end

    // ************************************************************
    // running and latched counts
    // ************************************************************

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            run_count     <= '0;
            run_err       <= '0;
            latched_count <= '0;
            latched_err   <= '0;
        end else begin
            if (latch) begin
                latched_count <= run_count;
                latched_err   <= run_err;
            end
            run_count <= next_count;
            run_err   <= next_err;
        end
    end

endmodule

`default_nettype wire

// File: logic/qenc_step_decoder.sv
`timescale 1ns/1ns
`default_nettype none

module qenc_step_decoder (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    filt_a,
    input  logic                    filt_b,
    output qenc_status_pkg::step_t  step
);

    import qenc_status_pkg::*;

    logic  prev_a;
    logic  prev_b;
    step_t step_next;

    // ************************************************************
    // transition table
    // ************************************************************

    // index is {prev_b, prev_a, b, a}
    // forward Gray order of {b, a} is 00, 01, 11, 10
    always_comb begin
        case ({prev_b, prev_a, filt_b, filt_a})
            4'b0001,
            4'b0111,
            4'b1110,
            4'b1000: step_next = STEP_UP;
            4'b0010,
            4'b1011,
            4'b1101,
            4'b0100: step_next = STEP_DOWN;
            // both lines moved at once
            4'b0011,
            4'b0110,
            4'b1001,
            4'b1100: step_next = STEP_ILLEGAL;
            default: step_next = STEP_NONE;
        endcase
    end

    // ************************************************************
    // phase and step registers
    // ************************************************************

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            prev_a <= 1'b0;
            prev_b <= 1'b0;
            step   <= STEP_NONE;
        end else begin
            prev_a <= filt_a;
            prev_b <= filt_b;
            step   <= step_next;
        end
    end

endmodule

`default_nettype wire

// File: logic/qenc_input_filter.sv
`timescale 1ns/1ns
`default_nettype none

module qenc_input_filter (
    input  logic clk,
    input  logic reset,
    input  logic swap,
    input  logic enc_a,
    input  logic enc_b,
    output logic filt_a,
    output logic filt_b
);

    logic [3:0] hist_a;
    logic [3:0] hist_b;

    // two of three vote
    function automatic logic majority(input logic [2:0] taps);
        return (taps[2] & taps[1]) | (taps[2] & taps[0]) | (taps[1] & taps[0]);
    endfunction

    // ************************************************************
    // sample history
    // ************************************************************

    // swap exchanges the lines before the first stage
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            hist_a <= '0;
            hist_b <= '0;
        end else begin
            hist_a <= {hist_a[2:0], swap ? enc_b : enc_a};
            hist_b <= {hist_b[2:0], swap ? enc_a : enc_b};
        end
    end

    // tap 0 is the raw sample and stays out of the vote
    assign filt_a = majority(hist_a[3:1]);
    assign filt_b = majority(hist_b[3:1]);

endmodule

`default_nettype wire

// File: logic/qenc_status_pkg.sv
`default_nettype none

`include "qenc_consts.svh"

package qenc_status_pkg;

    // decoded phase change
    typedef enum logic [1:0] {
        STEP_NONE    = 2'b00,
        STEP_UP      = 2'b01,
        STEP_DOWN    = 2'b10,
        STEP_ILLEGAL = 2'b11
    } step_t;

    typedef logic signed [`QENC_COUNT_WIDTH-1:0] count_t;

    typedef logic [`QENC_ERR_WIDTH-1:0] err_count_t;

endpackage

`default_nettype wire

// File: logic/qenc_cfg_pkg.sv
`default_nettype none

`include "qenc_consts.svh"

package qenc_cfg_pkg;

    // register map
    typedef enum logic [`QENC_ADDR_WIDTH-1:0] {
        ADDR_CTRL   = 0,
        ADDR_LATCH  = 1,
        ADDR_COUNT0 = 2,
        ADDR_COUNT1 = 3,
        ADDR_ERR0   = 4,
        ADDR_ERR1   = 5
    } reg_addr_t;

    // one bit per channel, used for swap and latch masks
    typedef logic [`QENC_CHANNELS-1:0] chan_mask_t;

endpackage

`default_nettype wire

// File: logic/qenc_consts.svh
`ifndef QENC_CONSTS_SVH
`define QENC_CONSTS_SVH

// ************************************************************
// capture block sizing
// ************************************************************

// encoder channels
`define QENC_CHANNELS 2

// running and latched position count, two's complement
`define QENC_COUNT_WIDTH 16

// illegal step count, saturating
`define QENC_ERR_WIDTH 8

// ************************************************************
// register port
// ************************************************************

`define QENC_ADDR_WIDTH 4

`define QENC_DATA_WIDTH 16

`endif
